//--- dv/alu_core_properties.sv
`include "alu_config.svh"

module alu_core_properties (
    input logic                    clk_in,
    input logic                    pull_rstk_in,
    input alu_pkg::alu_cmd_t       cmd_i,
    input logic                    set_carry_i,
    input logic                    clr_carry_i,
    input logic [`ALU_WORD_W-1:0]  data_o,
    input logic                    carry_o
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;
    logic [`ALU_WORD_W-1:0] outside; // nibbles outside the decoded field

    always_comb
    begin
        for (int i = 0; i < `ALU_NIBBLES; i++)
        begin
            outside[i*4 +: 4] = (i < cmd_i.lo_nib || i > cmd_i.hi_nib) ? 4'hf : 4'h0;
        end
    end

    set_carry_sets: assert property (@(posedge clk_in) disable iff (pull_rstk_in)
        set_carry_i && !clr_carry_i |=> carry_o)
        else
        begin
            fail_count++;
            $error("carry_o not set one cycle after set_carry_i");
        end

    clr_carry_wins: assert property (@(posedge clk_in) disable iff (pull_rstk_in)
        clr_carry_i |=> !carry_o)
        else
        begin
            fail_count++;
            $error("carry_o not cleared one cycle after clr_carry_i");
        end

    data_in_field: assert property (@(posedge clk_in) (data_o & outside) == '0)
        else
        begin
            fail_count++;
            $error("data_o has nonzero nibbles outside the field");
        end

    carry_after_reset: assert property (@(posedge clk_in) pull_rstk_in |=> !carry_o)
        else
        begin
            fail_count++;
            $error("carry_o not 0 after reset");
        end

endmodule

bind alu_core alu_core_properties i_alu_core_properties (.*);

//--- dv/alu_core_tb.sv
`include "alu_config.svh"

module alu_core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 4;
    localparam int MAX_OPS      = 150;
    localparam int WDOG_CYCLES  = RESET_CYCLES + MAX_OPS * 3 + 146; // 60 us

    logic                    clk_in;
    logic                    pull_rstk_in;
    alu_pkg::alu_cmd_t       cmd_i;
    logic [`ALU_WORD_W-1:0]  literal_i;
    logic [`ALU_WORD_W-1:0]  data_i;
    logic                    latch_i;
    logic                    write_dst_i;
    logic                    write_carry_i;
    logic                    set_carry_i;
    logic                    clr_carry_i;
    logic                    set_decimal_i;
    logic                    set_hex_i;
    logic [`ALU_WORD_W-1:0]  data_o;
    logic                    carry_o;

    logic [`ALU_WORD_W-1:0]  regs_m [`ALU_NUM_WREGS];
    logic                    carry_m;
    logic                    dec_m;

    alu_core i_alu_core (.*);

    always #(CLK_PERIOD / 2) clk_in = ~clk_in;

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (act === exp)
        else
        begin
            $display("ERROR %s expected %h actual %h", name, exp, act);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    function automatic logic [63:0] rand64();
        return {$urandom(), $urandom()};
    endfunction

    function automatic logic [63:0] rand_bcd();
        logic [63:0] v;
        for (int i = 0; i < `ALU_NIBBLES; i++)
        begin
            v[i*4 +: 4] = 4'($urandom_range(9));
        end
        return v;
    endfunction

    function automatic logic [63:0] field_bits(input int lo, input int hi);
        logic [63:0] m;
        for (int i = 0; i < `ALU_NIBBLES; i++)
        begin
            m[i*4 +: 4] = (i >= lo && i <= hi) ? 4'hf : 4'h0;
        end
        return m;
    endfunction

    function automatic alu_pkg::alu_cmd_t make_cmd(input alu_pkg::alu_op_e op,
        input alu_pkg::src_grp_e sg, input int si, input alu_pkg::src_grp_e og,
        input int oi, input int dst, input int lo, input int hi, input int fc, input int fh);
        alu_pkg::alu_cmd_t c;
        c.op           = op;
        c.src_sel.grp  = sg;
        c.src_sel.idx  = si[1:0];
        c.op2_sel.grp  = og;
        c.op2_sel.idx  = oi[1:0];
        c.dst_idx      = dst[1:0];
        c.lo_nib       = lo[3:0];
        c.hi_nib       = hi[3:0];
        c.forced_carry = fc[0];
        c.forced_hex   = fh[0];
        return c;
    endfunction

    function automatic logic [63:0] pick(input alu_pkg::src_sel_t sel, input logic [63:0] lit,
                                         input logic is_src);
        case (sel.grp)
            alu_pkg::grp_wreg:  return regs_m[sel.idx];
            alu_pkg::grp_mem:   return is_src ? data_i : 64'h0; // op2 has no memory path
            alu_pkg::grp_lit:   return lit;
            alu_pkg::grp_const: return dec_m ? {`ALU_NIBBLES{4'h9}} : '1;
            default:            return '0;
        endcase
    endfunction

    // returns {carry, result}
    function automatic logic [64:0] model_alu(input alu_pkg::alu_cmd_t c, input logic [63:0] s,
                                              input logic [63:0] t, input logic dec);
        logic [63:0] q;
        logic [63:0] x;
        logic [63:0] y;
        int          d;
        int          cy;
        int          base;
        q    = s;
        cy   = 0;
        base = dec ? 10 : 16;
        case (c.op)
            alu_pkg::op_add, alu_pkg::op_sub, alu_pkg::op_rsub:
            begin
                x  = (c.op == alu_pkg::op_rsub) ? t : s;
                y  = (c.op == alu_pkg::op_rsub) ? s : t;
                cy = c.forced_carry;
                for (int i = c.lo_nib; i <= c.hi_nib; i++)
                begin
                    if (c.op == alu_pkg::op_add)
                    begin
                        d = int'(x[i*4 +: 4]) + int'(y[i*4 +: 4]) + cy;
                    end
                    else
                    begin
                        d = int'(x[i*4 +: 4]) - int'(y[i*4 +: 4]) - cy;
                    end
                    cy = (d < 0 || d >= base) ? 1 : 0;
                    d  = (d < 0) ? d + base : ((d >= base) ? d - base : d);
                    q[i*4 +: 4] = d[3:0];
                end
            end
            alu_pkg::op_and:  q = s & t;
            alu_pkg::op_or:   q = s | t;
            alu_pkg::op_andn: q = s & ~t;
            alu_pkg::op_sl:   q = s << 4;
            alu_pkg::op_sr:   q = s >> 4;
            alu_pkg::op_slc:  q = (s << 4) | (s >> 60);
            alu_pkg::op_src:  q = (s >> 4) | (s << 60);
            alu_pkg::op_eq:   cy = (t == s);
            alu_pkg::op_neq:  cy = (t != s);
            alu_pkg::op_gt:   cy = (t > s);
            alu_pkg::op_gteq: cy = (t >= s);
            alu_pkg::op_lt:   cy = (t < s);
            alu_pkg::op_lteq: cy = (t <= s);
            default:          q = s;
        endcase
        return {cy[0], q};
    endfunction

    // called 10 ns after a rising edge
    task automatic read_reg(input string name, input int idx);
        cmd_i = make_cmd(alu_pkg::op_tfr, alu_pkg::grp_wreg, idx, alu_pkg::grp_zero, 0, 0,
                         0, 15, 0, 0);
        #40;
        check_value(name, regs_m[idx], data_o);
        check_value({name, " carry"}, {63'b0, carry_m}, {63'b0, carry_o});
    endtask

    // latch, write, read back
    task automatic run_op(input string name, input alu_pkg::alu_cmd_t cmd,
                          input logic [63:0] lit);
        logic [63:0] m;
        logic [63:0] s;
        logic [63:0] t;
        logic [64:0] r;
        m = field_bits(cmd.lo_nib, cmd.hi_nib);
        s = pick(cmd.src_sel, lit, 1'b1) & m;
        t = pick(cmd.op2_sel, lit, 1'b0) & m;
        r = model_alu(cmd, s, t, dec_m & ~cmd.forced_hex);
        @(posedge clk_in);
        #10;
        cmd_i     = cmd;
        literal_i = lit;
        latch_i   = 1'b1;
        @(posedge clk_in);
        #10;
        latch_i       = 1'b0;
        write_dst_i   = 1'b1;
        write_carry_i = 1'b1;
        @(posedge clk_in);
        #10;
        write_dst_i   = 1'b0;
        write_carry_i = 1'b0;
        regs_m[cmd.dst_idx] = (regs_m[cmd.dst_idx] & ~m) | (r[63:0] & m);
        carry_m = r[64];
        read_reg(name, cmd.dst_idx);
    endtask

    task automatic pulse_flags(input string name, input logic sc, input logic cc,
                               input logic sd, input logic sh);
        @(posedge clk_in);
        #10;
        set_carry_i   = sc;
        clr_carry_i   = cc;
        set_decimal_i = sd;
        set_hex_i     = sh;
        @(posedge clk_in);
        #10;
        set_carry_i   = 1'b0;
        clr_carry_i   = 1'b0;
        set_decimal_i = 1'b0;
        set_hex_i     = 1'b0;
        carry_m = cc ? 1'b0 : (sc ? 1'b1 : carry_m);
        dec_m   = sh ? 1'b0 : (sd ? 1'b1 : dec_m);
        #40;
        check_value(name, {63'b0, carry_m}, {63'b0, carry_o});
    endtask

    initial
    begin
        #(WDOG_CYCLES * CLK_PERIOD);
        $display("run timed out before all tests finished");
        $display("sim failed");
        $fatal(1);
    end

    always @(negedge clk_in)
    begin
        if (i_alu_core.i_alu_core_properties.fail_count != 0)
        begin
            $display("a bound property on alu_core failed");
            $display("sim failed");
            $fatal(1);
        end
    end

    initial
    begin
        int lo;
        int hi;
        void'($urandom(63));
        clk_in        = 1'b0;
        pull_rstk_in  = 1'b1;
        cmd_i         = '0;
        literal_i     = '0;
        data_i        = '0;
        latch_i       = 1'b0;
        write_dst_i   = 1'b0;
        write_carry_i = 1'b0;
        set_carry_i   = 1'b0;
        clr_carry_i   = 1'b0;
        set_decimal_i = 1'b0;
        set_hex_i     = 1'b0;
        regs_m        = '{default: '0};
        carry_m       = 1'b0;
        dec_m         = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_in);
        #10;
        pull_rstk_in = 1'b0;

        for (int k = 0; k < `ALU_NUM_WREGS; k++)
        begin
            @(posedge clk_in);
            #10;
            read_reg("reset", k);
        end
        for (int k = 0; k < `ALU_NUM_WREGS; k++)
        begin
            run_op("load", make_cmd(alu_pkg::op_tfr, alu_pkg::grp_lit, 0, alu_pkg::grp_zero,
                   0, k, 0, 15, 0, 0), rand64());
        end

        repeat (20)
        begin
            lo = $urandom_range(15);
            hi = $urandom_range(15, lo);
            run_op("hex_arith", make_cmd(alu_pkg::alu_op_e'(alu_pkg::op_add + $urandom_range(1)),
                   alu_pkg::grp_wreg, $urandom_range(3), alu_pkg::grp_lit, 0, $urandom_range(3),
                   lo, hi, $urandom_range(1), 0), rand64());
        end

        pulse_flags("set_decimal", 1'b0, 1'b0, 1'b1, 1'b0);
        run_op("bcd_const", make_cmd(alu_pkg::op_tfr, alu_pkg::grp_const, 0, alu_pkg::grp_zero,
               0, 2, 0, 15, 0, 0), '0);
        for (int k = 0; k < 2; k++)
        begin
            run_op("bcd_load", make_cmd(alu_pkg::op_tfr, alu_pkg::grp_lit, 0, alu_pkg::grp_zero,
                   0, k, 0, 15, 0, 0), rand_bcd());
        end
        repeat (12)
        begin
            lo = $urandom_range(15);
            hi = $urandom_range(15, lo);
            run_op("bcd_arith", make_cmd(alu_pkg::alu_op_e'(alu_pkg::op_add + $urandom_range(2)),
                   alu_pkg::grp_wreg, $urandom_range(1), alu_pkg::grp_lit, 0, $urandom_range(1),
                   lo, hi, $urandom_range(1), 0), rand_bcd());
        end
        run_op("forced_hex", make_cmd(alu_pkg::op_add, alu_pkg::grp_wreg, 0, alu_pkg::grp_lit, 0,
               3, 0, 15, 1, 1), rand_bcd());
        pulse_flags("set_hex", 1'b0, 1'b0, 1'b1, 1'b1); // hex beats decimal
        run_op("hex_const", make_cmd(alu_pkg::op_tfr, alu_pkg::grp_const, 0, alu_pkg::grp_zero,
               0, 2, 0, 15, 0, 0), '0);

        repeat (8)
        begin
            lo = $urandom_range(15);
            hi = $urandom_range(15, lo);
            run_op("rsub", make_cmd(alu_pkg::op_rsub, alu_pkg::grp_wreg, $urandom_range(3),
                   alu_pkg::grp_lit, 0, $urandom_range(3), lo, hi, $urandom_range(1), 0),
                   rand64());
        end
        for (int k = alu_pkg::op_eq; k <= alu_pkg::op_lteq; k++)
        begin
            run_op("compare", make_cmd(alu_pkg::alu_op_e'(k), alu_pkg::grp_wreg, 0,
                   alu_pkg::grp_lit, 0, 1, 0, 15, 0, 0), rand64());
            run_op("compare_equal", make_cmd(alu_pkg::alu_op_e'(k), alu_pkg::grp_wreg, 2,
                   alu_pkg::grp_wreg, 2, 3, 0, 15, 0, 0), '0);
            run_op("compare_zero", make_cmd(alu_pkg::alu_op_e'(k), alu_pkg::grp_wreg, 1,
                   alu_pkg::grp_lit, 0, 0, 0, 15, 0, 0), '0);
        end

        for (int k = alu_pkg::op_and; k <= alu_pkg::op_src; k++)
        begin
            repeat (2)
            begin
                run_op("logic_shift", make_cmd(alu_pkg::alu_op_e'(k), alu_pkg::grp_wreg,
                       $urandom_range(3), alu_pkg::grp_lit, 0, $urandom_range(3), 0, 15, 0, 0),
                       rand64());
            end
        end

        repeat (2)
        begin
            lo = $urandom_range(15);
            hi = $urandom_range(15, lo);
            @(posedge clk_in);
            #10;
            data_i = rand64();
            run_op("memory", make_cmd(alu_pkg::op_tfr, alu_pkg::grp_mem, 0, alu_pkg::grp_zero,
                   0, $urandom_range(3), lo, hi, 0, 0), '0);
        end
        pulse_flags("set_carry", 1'b1, 1'b0, 1'b0, 1'b0);
        pulse_flags("clr_carry", 1'b0, 1'b1, 1'b0, 1'b0);
        pulse_flags("set_carry", 1'b1, 1'b0, 1'b0, 1'b0);
        pulse_flags("clr_over_set", 1'b1, 1'b1, 1'b0, 1'b0);

        @(posedge clk_in);
        if (i_alu_core.i_alu_core_properties.fail_count != 0)
        begin
            $display("sim failed");
            $fatal(1);
        end
        else
        begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

//--- hdl/alu_config.svh
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// data word width
`define ALU_WORD_W 64

// one hex or BCD digit
`define ALU_NIBBLE_W 4

// digits per word
`define ALU_NIBBLES 16

// working registers A to D
`define ALU_NUM_WREGS 4

`endif

//--- hdl/alu_core.sv
`include "alu_config.svh"

module alu_core (
    input  logic                    clk_in,
    input  logic                    pull_rstk_in,
    input  alu_pkg::alu_cmd_t       cmd_i,
    input  logic [`ALU_WORD_W-1:0]  literal_i,
    input  logic [`ALU_WORD_W-1:0]  data_i,
    input  logic                    latch_i,
    input  logic                    write_dst_i,
    input  logic                    write_carry_i,
    input  logic                    set_carry_i,
    input  logic                    clr_carry_i,
    input  logic                    set_decimal_i,
    input  logic                    set_hex_i,
    output logic [`ALU_WORD_W-1:0]  data_o,
    output logic                    carry_o
);

    alu_pkg::field_mask_t field_mask;
    alu_pkg::alu_word_u   lat_src;
    alu_pkg::alu_word_u   lat_op2;
    alu_pkg::alu_word_u   alu_q;
    logic                 alu_carry;
    alu_pkg::reg_file_t   regs;
    logic                 decimal;

    field_decode i_field_decode (
        .clk_in       (clk_in),
        .pull_rstk_in (pull_rstk_in),
        .cmd_i        (cmd_i),
        .regs_i       (regs),
        .decimal_i    (decimal),
        .literal_i    (literal_i),
        .data_i       (data_i),
        .latch_i      (latch_i),
        .field_mask_o (field_mask),
        .data_o       (data_o),
        .lat_src_o    (lat_src),
        .lat_op2_o    (lat_op2)
    );

    alu_execute i_alu_execute (
        .cmd_i       (cmd_i),
        .lat_src_i   (lat_src),
        .lat_op2_i   (lat_op2),
        .decimal_i   (decimal),
        .alu_q_o     (alu_q),
        .alu_carry_o (alu_carry)
    );

    result_writeback i_result_writeback (
        .clk_in        (clk_in),
        .pull_rstk_in  (pull_rstk_in),
        .cmd_i         (cmd_i),
        .field_mask_i  (field_mask),
        .alu_q_i       (alu_q),
        .alu_carry_i   (alu_carry),
        .write_dst_i   (write_dst_i),
        .write_carry_i (write_carry_i),
        .set_carry_i   (set_carry_i),
        .clr_carry_i   (clr_carry_i),
        .set_decimal_i (set_decimal_i),
        .set_hex_i     (set_hex_i),
        .regs_o        (regs),
        .decimal_o     (decimal),
        .carry_o       (carry_o)
    );

endmodule

//--- hdl/alu_execute.sv
`include "alu_config.svh"

module alu_execute (
    input  alu_pkg::alu_cmd_t   cmd_i,
    input  alu_pkg::alu_word_u  lat_src_i,
    input  alu_pkg::alu_word_u  lat_op2_i,
    input  logic                decimal_i,
    output alu_pkg::alu_word_u  alu_q_o,
    output logic                alu_carry_o
);

    localparam int W = `ALU_WORD_W;
    localparam int N = `ALU_NIBBLE_W;

    logic               dec_eff;
    alu_pkg::alu_word_u add_q;
    alu_pkg::alu_word_u sub_q;
    alu_pkg::alu_word_u rsub_q;
    logic               add_c;
    logic               sub_c;
    logic               rsub_c;
    logic               cmp_eq;
    logic               cmp_gt;
    logic               cmp_lt;

    assign dec_eff = decimal_i & ~cmd_i.forced_hex; // all three chains

    bcd_nibble_chain #(.SUBTRACT(1'b0)) u_add (
        .a_i            (lat_src_i),
        .b_i            (lat_op2_i),
        .decimal_i      (dec_eff),
        .forced_carry_i (cmd_i.forced_carry),
        .lo_nib_i       (cmd_i.lo_nib),
        .hi_nib_i       (cmd_i.hi_nib),
        .q_o            (add_q),
        .carry_o        (add_c)
    );

    bcd_nibble_chain #(.SUBTRACT(1'b1)) u_sub (
        .a_i            (lat_src_i),
        .b_i            (lat_op2_i),
        .decimal_i      (dec_eff),
        .forced_carry_i (cmd_i.forced_carry),
        .lo_nib_i       (cmd_i.lo_nib),
        .hi_nib_i       (cmd_i.hi_nib),
        .q_o            (sub_q),
        .carry_o        (sub_c)
    );

    bcd_nibble_chain #(.SUBTRACT(1'b1)) u_rsub (
        .a_i            (lat_op2_i), // op2 minus source
        .b_i            (lat_src_i),
        .decimal_i      (dec_eff),
        .forced_carry_i (cmd_i.forced_carry),
        .lo_nib_i       (cmd_i.lo_nib),
        .hi_nib_i       (cmd_i.hi_nib),
        .q_o            (rsub_q),
        .carry_o        (rsub_c)
    );

    // op2 measured against the source
    assign cmp_eq = lat_op2_i.word == lat_src_i.word;
    assign cmp_gt = lat_op2_i.word >  lat_src_i.word;
    assign cmp_lt = lat_op2_i.word <  lat_src_i.word;

    always_comb
    begin
        case (cmd_i.op)
            alu_pkg::op_add:  alu_q_o = add_q;
            alu_pkg::op_sub:  alu_q_o = sub_q;
            alu_pkg::op_rsub: alu_q_o = rsub_q;
            alu_pkg::op_and:  alu_q_o.word = lat_src_i.word & lat_op2_i.word;
            alu_pkg::op_or:   alu_q_o.word = lat_src_i.word | lat_op2_i.word;
            alu_pkg::op_andn: alu_q_o.word = lat_src_i.word & ~lat_op2_i.word;
            alu_pkg::op_sl:   alu_q_o.word = {lat_src_i.word[W-N-1:0], {N{1'b0}}};
            alu_pkg::op_sr:   alu_q_o.word = {{N{1'b0}}, lat_src_i.word[W-1:N]};
            alu_pkg::op_slc:  alu_q_o.word = {lat_src_i.word[W-N-1:0], lat_src_i.word[W-1:W-N]};
            alu_pkg::op_src:  alu_q_o.word = {lat_src_i.word[N-1:0], lat_src_i.word[W-1:N]};
            default:          alu_q_o = lat_src_i; // tfr and compares
        endcase
    end

    always_comb
    begin
        case (cmd_i.op)
            alu_pkg::op_add:  alu_carry_o = add_c;
            alu_pkg::op_sub:  alu_carry_o = sub_c;
            alu_pkg::op_rsub: alu_carry_o = rsub_c;
            alu_pkg::op_eq:   alu_carry_o = cmp_eq;
            alu_pkg::op_neq:  alu_carry_o = ~cmp_eq;
            alu_pkg::op_gt:   alu_carry_o = cmp_gt;
            alu_pkg::op_gteq: alu_carry_o = cmp_gt | cmp_eq;
            alu_pkg::op_lt:   alu_carry_o = cmp_lt;
            alu_pkg::op_lteq: alu_carry_o = cmp_lt | cmp_eq;
            default:          alu_carry_o = 1'b0;
        endcase
    end

endmodule

//--- hdl/alu_pkg.sv
`include "alu_config.svh"

package alu_pkg;

    typedef enum logic [4:0] {
        op_tfr, op_add, op_sub, op_rsub,
        op_and, op_or, op_andn,
        op_sl, op_sr, op_slc, op_src,
        op_eq, op_neq, op_gt, op_gteq, op_lt, op_lteq
    } alu_op_e;

    typedef enum logic [2:0] {
        grp_wreg,   // A to D
        grp_mem,    // memory data, source only
        grp_lit,    // opcode literal
        grp_const,  // all nines or all F
        grp_zero
    } src_grp_e;

    typedef struct packed {
        src_grp_e   grp;
        logic [1:0] idx;
    } src_sel_t;

    typedef logic [$clog2(`ALU_NIBBLES)-1:0] nibble_idx_t;

    typedef logic [`ALU_NIBBLES-1:0] field_mask_t;

    // flat view for logic and compares, digit view for field work
    typedef union packed {
        logic [`ALU_WORD_W-1:0]                     word;
        logic [`ALU_NIBBLES-1:0][`ALU_NIBBLE_W-1:0] nib;
    } alu_word_u;

    typedef alu_word_u [`ALU_NUM_WREGS-1:0] reg_file_t;

    typedef struct packed {
        alu_op_e                              op;
        src_sel_t                             src_sel;
        src_sel_t                             op2_sel;
        logic [$clog2(`ALU_NUM_WREGS)-1:0]    dst_idx;
        nibble_idx_t                          lo_nib;
        nibble_idx_t                          hi_nib;
        logic                                 forced_carry;
        logic                                 forced_hex;
    } alu_cmd_t;

endpackage

//--- hdl/bcd_nibble_chain.sv
`include "alu_config.svh"

module bcd_nibble_chain #(
    parameter bit SUBTRACT = 1'b0
) (
    input  alu_pkg::alu_word_u    a_i,
    input  alu_pkg::alu_word_u    b_i,
    input  logic                  decimal_i,
    input  logic                  forced_carry_i,
    input  alu_pkg::nibble_idx_t  lo_nib_i,
    input  alu_pkg::nibble_idx_t  hi_nib_i,
    output alu_pkg::alu_word_u    q_o,
    output logic                  carry_o
);

    logic [`ALU_NIBBLES:0] c; // c[i] enters digit i

    always_comb
    begin
        c[0] = 1'b0;
        for (int i = 0; i < `ALU_NIBBLES; i++)
        begin
            logic       cin;
            logic [4:0] raw;
            logic       cout;
            cin = c[i] | (forced_carry_i && (lo_nib_i == alu_pkg::nibble_idx_t'(i)));
            if (SUBTRACT)
            begin
                raw  = {1'b0, a_i.nib[i]} - {1'b0, b_i.nib[i]} - {4'h0, cin};
                cout = raw[4]; // borrow
                if (decimal_i && cout)
                begin
                    q_o.nib[i] = raw[3:0] - 4'h6;
                end
                else
                begin
                    q_o.nib[i] = raw[3:0];
                end
            end
            else
            begin
                raw  = {1'b0, a_i.nib[i]} + {1'b0, b_i.nib[i]} + {4'h0, cin};
                cout = decimal_i ? (raw > 5'd9) : raw[4];
                if (decimal_i && cout)
                begin
                    q_o.nib[i] = raw[3:0] + 4'h6; // skip a to f
                end
                else
                begin
                    q_o.nib[i] = raw[3:0];
                end
            end
            c[i+1] = cout;
        end
    end

    // carry leaving the top digit of the field
    assign carry_o = c[{1'b0, hi_nib_i} + 5'd1];

endmodule

//--- hdl/field_decode.sv
`include "alu_config.svh"

module field_decode (
    input  logic                  clk_in,
    input  logic                  pull_rstk_in,
    input  alu_pkg::alu_cmd_t     cmd_i,
    input  alu_pkg::reg_file_t    regs_i,
    input  logic                  decimal_i,
    input  alu_pkg::alu_word_u    literal_i,
    input  alu_pkg::alu_word_u    data_i,
    input  logic                  latch_i,
    output alu_pkg::field_mask_t  field_mask_o,
    output alu_pkg::alu_word_u    data_o,
    output alu_pkg::alu_word_u    lat_src_o,
    output alu_pkg::alu_word_u    lat_op2_o
);

    localparam logic [`ALU_WORD_W-1:0] ALL_NINES = {`ALU_NIBBLES{4'h9}};
    localparam logic [`ALU_WORD_W-1:0] ALL_F     = {`ALU_NIBBLES{4'hf}};

    alu_pkg::alu_word_u src_raw;
    alu_pkg::alu_word_u op2_raw;
    alu_pkg::alu_word_u src_masked;
    alu_pkg::alu_word_u op2_masked;

    always_comb
    begin
        for (int i = 0; i < `ALU_NIBBLES; i++)
        begin
            field_mask_o[i] = (alu_pkg::nibble_idx_t'(i) >= cmd_i.lo_nib) &&
                              (alu_pkg::nibble_idx_t'(i) <= cmd_i.hi_nib);
        end
    end

    always_comb
    begin
        case (cmd_i.src_sel.grp)
            alu_pkg::grp_wreg:  src_raw = regs_i[cmd_i.src_sel.idx];
            alu_pkg::grp_mem:   src_raw = data_i;
            alu_pkg::grp_lit:   src_raw = literal_i;
            alu_pkg::grp_const: src_raw.word = decimal_i ? ALL_NINES : ALL_F;
            default:            src_raw.word = '0;
        endcase
    end

    // no memory path on the second operand
    always_comb
    begin
        case (cmd_i.op2_sel.grp)
            alu_pkg::grp_wreg:  op2_raw = regs_i[cmd_i.op2_sel.idx];
            alu_pkg::grp_lit:   op2_raw = literal_i;
            alu_pkg::grp_const: op2_raw.word = decimal_i ? ALL_NINES : ALL_F;
            default:            op2_raw.word = '0;
        endcase
    end

    always_comb
    begin
        for (int i = 0; i < `ALU_NIBBLES; i++)
        begin
            src_masked.nib[i] = field_mask_o[i] ? src_raw.nib[i] : '0;
            op2_masked.nib[i] = field_mask_o[i] ? op2_raw.nib[i] : '0;
        end
    end

    assign data_o = src_masked; // memory write data

    always_ff @(posedge clk_in)
    begin
        if (pull_rstk_in)
        begin
            lat_src_o <= '0;
            lat_op2_o <= '0;
        end
        else if (latch_i)
        begin
            lat_src_o <= src_masked;
            lat_op2_o <= op2_masked;
        end
    end

endmodule

//--- hdl/result_writeback.sv
`include "alu_config.svh"

module result_writeback (
    input  logic                  clk_in,
    input  logic                  pull_rstk_in,
    input  alu_pkg::alu_cmd_t     cmd_i,
    input  alu_pkg::field_mask_t  field_mask_i,
    input  alu_pkg::alu_word_u    alu_q_i,
    input  logic                  alu_carry_i,
    input  logic                  write_dst_i,
    input  logic                  write_carry_i,
    input  logic                  set_carry_i,
    input  logic                  clr_carry_i,
    input  logic                  set_decimal_i,
    input  logic                  set_hex_i,
    output alu_pkg::reg_file_t    regs_o,
    output logic                  decimal_o,
    output logic                  carry_o
);

    alu_pkg::reg_file_t regs;
    logic               f_carry;
    logic               f_decimal;

    // only the digits inside the field change
    always_ff @(posedge clk_in)
    begin
        if (pull_rstk_in)
        begin
            regs <= '0;
        end
        else if (write_dst_i)
        begin
            for (int i = 0; i < `ALU_NIBBLES; i++)
            begin
                if (field_mask_i[i])
                begin
                    regs[cmd_i.dst_idx].nib[i] <= alu_q_i.nib[i];
                end
            end
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (pull_rstk_in)
        begin
            f_carry <= 1'b0;
        end
        else if (clr_carry_i)
        begin
            f_carry <= 1'b0;
        end
        else if (set_carry_i)
        begin
            f_carry <= 1'b1;
        end
        else if (write_carry_i)
        begin
            f_carry <= alu_carry_i;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (pull_rstk_in)
        begin
            f_decimal <= 1'b0; // hex after reset
        end
        else if (set_hex_i)
        begin
            f_decimal <= 1'b0;
        end
        else if (set_decimal_i)
        begin
            f_decimal <= 1'b1;
        end
    end

    assign regs_o    = regs;
    assign decimal_o = f_decimal;
    assign carry_o   = f_carry;

endmodule

//--- src.f
+incdir+hdl
hdl/alu_pkg.sv
hdl/field_decode.sv
hdl/bcd_nibble_chain.sv
hdl/alu_execute.sv
hdl/result_writeback.sv
hdl/alu_core.sv
dv/alu_core_properties.sv
dv/alu_core_tb.sv
